/* rbzero_top.f */
+incdir+verilog
verilog/rbz_pkg.sv
verilog/vga_sync.sv
verilog/reg_spi.sv
verilog/tex_qspi.sv
verilog/wall_column.sv
verilog/rbzero_top.sv
verif/flash_model.sv
verif/tb_rbzero.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_rbzero -f rbzero_top.f -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "^Done: no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* verif/tb_rbzero.sv */
`timescale 1ns/1ps

module tb_rbzero;

  localparam int H_VIEW       = 640;
  localparam int H_HALF       = 320;
  localparam int H_SYNC_START = 656;
  localparam int H_SYNC_END   = 752;
  localparam int H_TOTAL      = 800;
  localparam int V_VIEW       = 480;
  localparam int V_SYNC_START = 490;
  localparam int V_SYNC_END   = 492;
  localparam int V_TOTAL      = 525;
  localparam int FRAME_CLKS   = H_TOTAL * V_TOTAL;
  localparam int WATCHDOG_NS  = 6 * FRAME_CLKS * 10;  // Tests run a bit over three frames

  localparam logic [7:0] CMD_SKY     = 8'd0;
  localparam logic [7:0] CMD_FLOOR   = 8'd1;
  localparam logic [7:0] CMD_VSHIFT  = 8'd2;
  localparam logic [7:0] CMD_SLICE   = 8'd3;
  localparam logic [7:0] CMD_TEXADD0 = 8'd5;

  logic        clk, reset;
  logic        reg_ss_n, reg_sclk, reg_mosi;
  logic        tex_csb, tex_sclk, tex_out0, tex_oeb0;
  logic [2:0]  tex_in;
  logic        hsync_n, vsync_n, hblank, vblank;
  logic [5:0]  rgb;
  logic [9:0]  hpos, vpos;
  logic [7:0]  cap_cmd;   // Seen by the flash model
  logic [23:0] cap_addr;

  int          err_count;
  int unsigned seed_ret;
  logic [5:0]  exp_sky, exp_floor;                  // Committed state the screen should show
  int          exp_wall, exp_half, exp_vshift, exp_addr;

  rbzero_top dut0 (
    .clk        (clk),
    .reset      (reset),
    .i_reg_ss_n (reg_ss_n),
    .i_reg_sclk (reg_sclk),
    .i_reg_mosi (reg_mosi),
    .o_tex_csb  (tex_csb),
    .o_tex_sclk (tex_sclk),
    .o_tex_out0 (tex_out0),
    .o_tex_oeb0 (tex_oeb0),
    .i_tex_in   (tex_in),
    .o_hsync_n  (hsync_n),
    .o_vsync_n  (vsync_n),
    .o_rgb      (rgb),
    .o_hblank   (hblank),
    .o_vblank   (vblank),
    .o_hpos     (hpos),
    .o_vpos     (vpos)
  );

  flash_model flash0 (
    .i_sclk (tex_sclk),
    .i_csb  (tex_csb),
    .i_io0  (tex_out0),
    .o_io   (tex_in),
    .o_cmd  (cap_cmd),
    .o_addr (cap_addr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Done: errors found");
    $finish;
  end

  task automatic step_clk;  // Inputs change 1 ns after the edge once outputs have settled
    @(posedge clk);
    #1;
  endtask

  task automatic wait_pos(input int v, input int h);
    while (vpos !== 10'(v) || hpos !== 10'(h)) step_clk();
  endtask

  task automatic report_mismatch(input string what, input int got, input int expected);
    err_count++;
    $display("error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
  endtask

  task automatic send_bit(input logic b);
    reg_mosi = b;
    repeat (4) step_clk();
    reg_sclk = 1'b1;        // Slave samples here
    repeat (4) step_clk();
    reg_sclk = 1'b0;
  endtask

  // Command byte then payload in MSB first order
  task automatic spi_write(input logic [7:0] cmd, input logic [23:0] data, input int nbits);
    logic [31:0] word;
    int          i;
    word = {cmd, data << (24 - nbits)};
    reg_ss_n = 1'b0;
    repeat (4) step_clk();
    for (i = 0; i < 8 + nbits; i++) begin
      send_bit(word[31]);
      word = word << 1;
    end
    repeat (4) step_clk();
    reg_ss_n = 1'b1;        // Shadow takes the value on deselect
    repeat (4) step_clk();
    reg_mosi = 1'b0;
  endtask

  // Pixel colour from the committed registers and the flash pattern
  function automatic logic [5:0] exp_pixel(input int x);
    int start;
    int k;
    start = H_HALF - exp_half;
    if (x >= H_VIEW) return 6'd0;                  // Blank
    if (exp_wall != 0 && x >= start && x < H_HALF + exp_half) begin
      k = ((x - start) / 8 + exp_vshift) % 64;    // 8 pixels per texel
      return 6'((exp_addr + k) % 64);
    end
    if (x < H_HALF) return exp_floor;
    return exp_sky;
  endfunction

  task automatic scan_line(input int v);
    int         x;
    logic [5:0] exp_rgb;
    wait_pos(v, 0);
    for (x = 0; x < H_TOTAL; x++) begin
      step_clk();                                   // o_rgb now shows pixel x
      exp_rgb = exp_pixel(x);
      if (rgb !== exp_rgb)
        report_mismatch($sformatf("o_rgb at line %0d pixel %0d", v, x), int'(rgb), int'(exp_rgb));
    end
  endtask

  task automatic after_reset_state;
    if (tex_csb !== 1'b1) report_mismatch("o_tex_csb after reset", int'(tex_csb), 1);
    if (rgb !== 6'd0) report_mismatch("o_rgb after reset", int'(rgb), 0);
    if (hsync_n !== 1'b1) report_mismatch("o_hsync_n after reset", int'(hsync_n), 1);
    if (vsync_n !== 1'b1) report_mismatch("o_vsync_n after reset", int'(vsync_n), 1);
    if (hpos !== 10'd0) report_mismatch("o_hpos after reset", int'(hpos), 0);
    if (vpos !== 10'd0) report_mismatch("o_vpos after reset", int'(vpos), 0);
    scan_line(0);           // Default floor and sky with black in blank
  endtask

  // One whole frame against the testbench's own counters
  task automatic sync_timing;
    int   n, h, v, low_cnt;
    logic prev_blank, exp_hs_n, exp_vs_n;
    h = 0;
    v = 1;                  // Line 0 scan ends here
    low_cnt = 0;
    prev_blank = 1'b1;      // Pixel 799 of line 0
    for (n = 0; n < FRAME_CLKS; n++) begin
      exp_hs_n = !(h >= H_SYNC_START && h < H_SYNC_END);
      exp_vs_n = !(v >= V_SYNC_START && v < V_SYNC_END);
      if (hpos !== 10'(h)) report_mismatch($sformatf("o_hpos at clock %0d", n), int'(hpos), h);
      if (vpos !== 10'(v)) report_mismatch($sformatf("o_vpos at clock %0d", n), int'(vpos), v);
      if (hsync_n !== exp_hs_n)
        report_mismatch($sformatf("o_hsync_n at %0d,%0d", v, h), int'(hsync_n), int'(exp_hs_n));
      if (vsync_n !== exp_vs_n)
        report_mismatch($sformatf("o_vsync_n at %0d,%0d", v, h), int'(vsync_n), int'(exp_vs_n));
      if (hblank !== (h >= H_VIEW))
        report_mismatch($sformatf("o_hblank at %0d,%0d", v, h), int'(hblank), int'(h >= H_VIEW));
      if (vblank !== (v >= V_VIEW))
        report_mismatch($sformatf("o_vblank at %0d,%0d", v, h), int'(vblank), int'(v >= V_VIEW));
      if (prev_blank && rgb !== 6'd0)
        report_mismatch($sformatf("o_rgb after blank pixel near %0d,%0d", v, h), int'(rgb), 0);
      if (v == 1 && hsync_n === 1'b0) low_cnt++;
      prev_blank = (h >= H_VIEW) || (v >= V_VIEW);
      step_clk();
      h++;
      if (h == H_TOTAL) begin
        h = 0;
        v = (v + 1) % V_TOTAL;
      end
    end
    if (low_cnt != 96) report_mismatch("hsync low clocks on line 1", low_cnt, 96);
  endtask

  task automatic register_commit;
    logic [5:0] new_sky, new_floor;
    wait_pos(200, 0);       // Mid-frame
    new_sky   = 6'($urandom_range(63, 0));
    new_floor = 6'($urandom_range(63, 0));
    if (new_sky == exp_sky) new_sky = ~new_sky;          // Change must be visible
    if (new_floor == exp_floor) new_floor = ~new_floor;
    spi_write(CMD_SKY, 24'(new_sky), 6);
    spi_write(CMD_FLOOR, 24'(new_floor), 6);
    scan_line(300);         // Old colours until frame end
    scan_line(470);
    exp_sky   = new_sky;
    exp_floor = new_floor;
    scan_line(10);          // Next frame
  endtask

  task automatic texture_request;
    int          wall_id, side, texu, addend, vshift, base, n, low_cnt, oeb_at, csb_first;
    logic [17:0] slice_word;
    wall_id = $urandom_range(3, 1);
    side    = $urandom_range(1, 0);
    texu    = $urandom_range(63, 0);
    addend  = $urandom_range(32'h00FF_FFFF, 0);
    vshift  = $urandom_range(63, 0);
    slice_word = {2'(wall_id), 1'(side), 6'(texu), 9'd64};   // Half-size 64
    spi_write(CMD_SLICE, 24'(slice_word), 18);
    spi_write(CMD_TEXADD0 + 8'(wall_id - 1), 24'(addend), 24);
    spi_write(CMD_VSHIFT, 24'(vshift), 6);
    // Slice base has texel 0 with texu at bit 6, side at bit 12 and wall index at bit 13
    base = ((wall_id - 1) << 13) + (side << 12) + (texu << 6);
    wait_pos(0, 0);         // Committed at the last frame end
    exp_wall   = wall_id;
    exp_half   = 64;
    exp_vshift = vshift;
    exp_addr   = (base + addend) & 32'h00FF_FFFF;
    low_cnt    = 0;
    oeb_at     = -1;
    csb_first  = -1;
    for (n = 0; n < H_TOTAL; n++) begin
      step_clk();
      if (tex_sclk !== 1'b0)  // Inverted clk is low just after the rising edge
        report_mismatch($sformatf("o_tex_sclk at hpos %0d", hpos), int'(tex_sclk), 0);
      if (tex_csb === 1'b0) begin
        if (csb_first < 0) csb_first = int'(hpos);
        if (tex_oeb0 === 1'b1 && oeb_at < 0) oeb_at = low_cnt;  // Clocks of csb low so far
        low_cnt++;
      end
    end
    if (csb_first != 600) report_mismatch("hpos of csb fall", csb_first, 600);
    if (low_cnt != 168) report_mismatch("csb low clocks on line 0", low_cnt, 168);
    if (oeb_at != 32) report_mismatch("csb low clocks before oeb0 rise", oeb_at, 32);
    if (cap_cmd !== 8'h6B) report_mismatch("flash command", int'(cap_cmd), 8'h6B);
    if (cap_addr !== 24'(exp_addr)) report_mismatch("flash address", int'(cap_addr), exp_addr);
  endtask

  task automatic textured_wall;
    scan_line(1);           // Texels fetched in line 0 blank
    scan_line(2);
  endtask

  initial begin
    reset      = 1'b1;
    reg_ss_n   = 1'b1;
    reg_sclk   = 1'b0;
    reg_mosi   = 1'b0;
    err_count  = 0;
    exp_sky    = 6'b010101; // Reset colours
    exp_floor  = 6'b101010;
    exp_wall   = 0;
    exp_half   = 0;
    exp_vshift = 0;
    exp_addr   = 0;
    seed_ret   = $urandom(32'hf999_cd93);
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;
    after_reset_state();
    sync_timing();
    register_commit();
    texture_request();
    textured_wall();
    $display("Checks finished with %0d errors", err_count);
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* verif/flash_model.sv */
`timescale 1ns/1ps

module flash_model (
  input  logic        i_sclk,
  input  logic        i_csb,
  input  logic        i_io0,    // Command and address from the master
  output logic [2:0]  o_io,     // Data out on io[2:0], b g r
  output logic [7:0]  o_cmd,    // Last command seen
  output logic [23:0] o_addr    // Last address seen
);

  logic [7:0] clk_cnt;   // sclk rises since select
  logic [7:0] nib;       // Data nibble number
  logic [5:0] byte_val;  // Byte k holds colour (addr + k) mod 64, BBGGRR

  initial begin
    clk_cnt <= '0;
    o_io    <= '0;
    o_cmd   <= '0;
    o_addr  <= '0;
  end

  always @(posedge i_sclk) begin
    if (i_csb) begin
      clk_cnt <= '0;
    end else begin
      if (clk_cnt < 8'd8) o_cmd <= {o_cmd[6:0], i_io0};        // 8 command bits
      else if (clk_cnt < 8'd32) o_addr <= {o_addr[22:0], i_io0}; // 24 address bits
      if (clk_cnt != 8'hff) clk_cnt <= clk_cnt + 8'd1;
    end
  end

  // Data moves on falling sclk after 8 dummy clocks, low nibble of each byte first
  always @(negedge i_sclk) begin
    nib      = clk_cnt - 8'd40;
    byte_val = o_addr[5:0] + nib[6:1];
    if (clk_cnt >= 8'd40 && clk_cnt < 8'd168) begin
      o_io <= nib[0] ? {byte_val[5], byte_val[3], byte_val[1]}   // Colour MSBs
                     : {byte_val[4], byte_val[2], byte_val[0]};  // Colour LSBs
    end else begin
      o_io <= '0;
    end
  end

endmodule

/* verilog/rbzero_top.sv */
`timescale 1ns/1ps

module rbzero_top
  import rbz_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  // Register SPI slave
  input  logic       i_reg_ss_n,
  input  logic       i_reg_sclk,
  input  logic       i_reg_mosi,
  // Texture flash, QSPI master
  output logic       o_tex_csb,
  output logic       o_tex_sclk,
  output logic       o_tex_out0,
  output logic       o_tex_oeb0,
  input  logic [2:0] i_tex_in,
  // VGA
  output logic       o_hsync_n,
  output logic       o_vsync_n,
  output logic [5:0] o_rgb,
  output logic       o_hblank,
  output logic       o_vblank,
  output logic [9:0] o_hpos,
  output logic [9:0] o_vpos
);

  logic            hsync, vsync;
  logic            visible;
  logic            frame_end;
  logic [5:0]      sky, floor, vshift;
  logic [1:0]      wall;
  logic [8:0]      half_size;
  rbz_slice_addr_u slice_addr;
  logic [23:0]     tex_addend;
  logic [5:0]      texv;
  logic [5:0]      texel_rgb;

  assign o_hsync_n = ~hsync;  // Negative syncs for 640x480
  assign o_vsync_n = ~vsync;

  vga_sync vga_sync0 (
    .clk         (clk),
    .reset       (reset),
    .o_hpos      (o_hpos),
    .o_vpos      (o_vpos),
    .o_hsync     (hsync),
    .o_vsync     (vsync),
    .o_hblank    (o_hblank),
    .o_vblank    (o_vblank),
    .o_visible   (visible),
    .o_hmax      (),           // Line end only used inside the counter
    .o_frame_end (frame_end)
  );

  reg_spi reg_spi0 (
    .clk          (clk),
    .reset        (reset),
    .i_frame_end  (frame_end),
    .i_ss_n       (i_reg_ss_n),
    .i_sclk       (i_reg_sclk),
    .i_mosi       (i_reg_mosi),
    .o_sky        (sky),
    .o_floor      (floor),
    .o_vshift     (vshift),
    .o_wall       (wall),
    .o_half_size  (half_size),
    .o_slice_addr (slice_addr),
    .o_tex_addend (tex_addend)
  );

  // Fetch in hblank feeds the following lines
  tex_qspi tex_qspi0 (
    .clk          (clk),
    .reset        (reset),
    .i_hpos       (o_hpos),
    .i_slice_addr (slice_addr),
    .i_tex_addend (tex_addend),
    .i_tex_in     (i_tex_in),
    .i_texv       (texv),
    .o_tex_csb    (o_tex_csb),
    .o_tex_sclk   (o_tex_sclk),
    .o_tex_out0   (o_tex_out0),
    .o_tex_oeb0   (o_tex_oeb0),
    .o_texel_rgb  (texel_rgb)
  );

  wall_column wall_column0 (
    .clk         (clk),
    .reset       (reset),
    .i_hpos      (o_hpos),
    .i_visible   (visible),
    .i_wall      (wall),
    .i_half_size (half_size),
    .i_vshift    (vshift),
    .i_sky       (sky),
    .i_floor     (floor),
    .i_texel_rgb (texel_rgb),
    .o_texv      (texv),
    .o_rgb       (o_rgb)
  );

endmodule

/* verilog/wall_column.sv */
`timescale 1ns/1ps
`include "rbz_consts.svh"

module wall_column (
  input  logic       clk,
  input  logic       reset,
  input  logic [9:0] i_hpos,
  input  logic       i_visible,
  input  logic [1:0] i_wall,        // 0 means no wall
  input  logic [8:0] i_half_size,
  input  logic [5:0] i_vshift,
  input  logic [5:0] i_sky,
  input  logic [5:0] i_floor,
  input  logic [5:0] i_texel_rgb,   // Texel at o_texv, same cycle
  output logic [5:0] o_texv,
  output logic [5:0] o_rgb          // One clock behind hpos
);

  logic [10:0] span_pos;   // hpos + half_size, span starts where this hits 320
  logic [10:0] span_off;   // Pixels from span start
  logic        in_span;
  logic        left_half;

  // Span is [320 - half, 320 + half); all terms kept non-negative
  assign span_pos = {1'b0, i_hpos} + {2'b00, i_half_size};
  assign in_span  = (span_pos >= 11'(`RBZ_HALF_VIEW)) &&
                    ({1'b0, i_hpos} < 11'(`RBZ_HALF_VIEW) + {2'b00, i_half_size});
  assign span_off = span_pos - 11'(`RBZ_HALF_VIEW);

  // Each texel stretched over 8 pixels, then shifted, wrapping at 64
  assign o_texv = span_off[8:3] + i_vshift;

  assign left_half = (i_hpos < 10'(`RBZ_HALF_VIEW));

  always_ff @(posedge clk) begin
    if (reset) begin
      o_rgb <= '0;
    end else if (!i_visible) begin
      o_rgb <= '0;                 // Black in blanking
    end else if (i_wall != 2'd0 && in_span) begin
      o_rgb <= i_texel_rgb;
    end else if (left_half) begin
      o_rgb <= i_floor;            // Floor on the left
    end else begin
      o_rgb <= i_sky;
    end
  end

endmodule

/* verilog/tex_qspi.sv */
`timescale 1ns/1ps
`include "rbz_consts.svh"

module tex_qspi
  import rbz_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic [9:0]      i_hpos,
  input  rbz_slice_addr_u i_slice_addr,  // Stable all frame
  input  logic [23:0]     i_tex_addend,
  input  logic [2:0]      i_tex_in,      // Flash io[2:0], io3 is not wired
  input  logic [5:0]      i_texv,
  output logic            o_tex_csb,
  output logic            o_tex_sclk,
  output logic            o_tex_out0,
  output logic            o_tex_oeb0,    // 1 when io[0] is an input
  output logic [5:0]      o_texel_rgb
);

  localparam logic [7:0] TSPI_CMD = `RBZ_TSPI_CMD;

  logic [9:0]  state;          // Stream state of this clock
  logic [9:0]  next_state;     // Stream state of the next clock
  logic [23:0] start_addr;
  logic [2:0]  cmd_idx;
  logic [4:0]  addr_idx;
  logic        out0_next;
  logic        data_present;
  logic [`RBZ_TEXEL_COUNT-1:0] tex_r0, tex_r1;
  logic [`RBZ_TEXEL_COUNT-1:0] tex_g0, tex_g1;
  logic [`RBZ_TEXEL_COUNT-1:0] tex_b0, tex_b1;

  // Flash clock runs flat out; out0 changes on clk rise, flash samples half a clock later
  assign o_tex_sclk = ~clk;

  // Stream runs from hpos 600 into hblank, states before hpos 600 wrap high
  assign state      = i_hpos - 10'(`RBZ_TSPI_READ_START);
  assign next_state = i_hpos - 10'(`RBZ_TSPI_READ_START - 1);

  assign start_addr = i_slice_addr.raw + i_tex_addend;
  assign cmd_idx    = 3'd7 - next_state[2:0];    // MSB first
  assign addr_idx   = 5'd31 - next_state[4:0];   // 23 down to 0 over states 8..31

  assign out0_next =
    (next_state < 10'(`RBZ_TSPI_CMD_LEN))  ? TSPI_CMD[cmd_idx] :
    (next_state < 10'(`RBZ_TSPI_ADDR_END)) ? start_addr[addr_idx] :
    1'b0;                                        // Dummy clocks and data phase

  // Pins are registered one state ahead, so they line up with hpos exactly
  always_ff @(posedge clk) begin
    if (reset) begin
      o_tex_csb  <= 1'b1;
      o_tex_out0 <= 1'b0;
      o_tex_oeb0 <= 1'b1;
    end else begin
      o_tex_csb  <= !(next_state < 10'(`RBZ_TSPI_STREAM_LEN));
      o_tex_out0 <= out0_next;
      o_tex_oeb0 <= (next_state >= 10'(`RBZ_TSPI_ADDR_END));
    end
  end

  // 128 nibbles after the preamble
  assign data_present = (state >= 10'(`RBZ_TSPI_PREAMBLE_LEN)) &&
                        (state < 10'(`RBZ_TSPI_STREAM_LEN));

  // Sample where flash data is stable; each buffer fills from the top,
  // so texel 0 ends at index 0
  always_ff @(posedge o_tex_sclk) begin
    if (data_present) begin
      if (!state[0]) begin
        // Low nibble, colour LSBs
        tex_r0 <= {i_tex_in[0], tex_r0[`RBZ_TEXEL_COUNT-1:1]};
        tex_g0 <= {i_tex_in[1], tex_g0[`RBZ_TEXEL_COUNT-1:1]};
        tex_b0 <= {i_tex_in[2], tex_b0[`RBZ_TEXEL_COUNT-1:1]};
      end else begin
        // High nibble, colour MSBs
        tex_r1 <= {i_tex_in[0], tex_r1[`RBZ_TEXEL_COUNT-1:1]};
        tex_g1 <= {i_tex_in[1], tex_g1[`RBZ_TEXEL_COUNT-1:1]};
        tex_b1 <= {i_tex_in[2], tex_b1[`RBZ_TEXEL_COUNT-1:1]};
      end
    end
  end

  assign o_texel_rgb = {tex_b1[i_texv], tex_b0[i_texv],
                        tex_g1[i_texv], tex_g0[i_texv],
                        tex_r1[i_texv], tex_r0[i_texv]};  // BBGGRR

endmodule

/* verilog/reg_spi.sv */
`timescale 1ns/1ps
`include "rbz_consts.svh"

module reg_spi
  import rbz_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            i_frame_end,   // Commit strobe
  input  logic            i_ss_n,        // Async SPI pins
  input  logic            i_sclk,
  input  logic            i_mosi,
  output logic [5:0]      o_sky,
  output logic [5:0]      o_floor,
  output logic [5:0]      o_vshift,
  output logic [1:0]      o_wall,        // 0 means no wall
  output logic [8:0]      o_half_size,
  output rbz_slice_addr_u o_slice_addr,
  output logic [23:0]     o_tex_addend   // Addend for the current wall only
);

  logic [2:0]  ss_sr;                      // [1] is synced, [2] is the previous sample
  logic [2:0]  sclk_sr;
  logic [1:0]  mosi_sr;
  logic        ss_active, ss_rise, sclk_rise, mosi_bit;
  logic [5:0]  bit_cnt;                    // Saturates, so overlong transfers are dropped
  logic [7:0]  cmd;
  logic [23:0] payload;                    // Last bits shifted in, right aligned
  logic [5:0]  payload_len;
  logic        xfer_done;
  logic [5:0]  sky_sh, floor_sh, vshift_sh;
  logic [1:0]  wall_sh;
  logic        side_sh, side_r;
  logic [5:0]  texu_sh, texu_r;
  logic [8:0]  half_sh;
  logic [23:0] texadd_sh [4];
  logic [23:0] texadd_r [4];
  logic [1:0]  wall_idx;

  always_ff @(posedge clk) begin
    if (reset) begin
      ss_sr   <= 3'b111;                   // Deselected, no false edge
      sclk_sr <= 3'b000;
    end else begin
      ss_sr   <= {ss_sr[1:0], i_ss_n};
      sclk_sr <= {sclk_sr[1:0], i_sclk};
    end
  end

  always_ff @(posedge clk) begin
    mosi_sr <= {mosi_sr[0], i_mosi};       // Same depth as sclk_sr[1]
  end

  assign ss_active = !ss_sr[1];
  assign ss_rise   = ss_sr[1] && !ss_sr[2];
  assign sclk_rise = sclk_sr[1] && !sclk_sr[2];
  assign mosi_bit  = mosi_sr[1];

  always_ff @(posedge clk) begin
    if (reset || !ss_active) begin
      bit_cnt <= '0;
      cmd     <= '0;
    end else if (sclk_rise) begin
      if (bit_cnt < 6'd8) cmd <= {cmd[6:0], mosi_bit};  // Command byte, MSB first
      if (bit_cnt != 6'd63) bit_cnt <= bit_cnt + 6'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (ss_active && sclk_rise && bit_cnt >= 6'd8) begin
      payload <= {payload[22:0], mosi_bit};
    end
  end

  always_comb begin
    case (cmd)
      `RBZ_CMD_SKY, `RBZ_CMD_FLOOR, `RBZ_CMD_VSHIFT: payload_len = 6'd6;
      `RBZ_CMD_SLICE:                                payload_len = 6'd18;
      `RBZ_CMD_TEXADD0, `RBZ_CMD_TEXADD1,
      `RBZ_CMD_TEXADD2, `RBZ_CMD_TEXADD3:            payload_len = 6'd24;
      default:                                       payload_len = 6'd0;
    endcase
  end

  // Only an exact bit count on deselect counts as a write
  assign xfer_done = ss_rise && (bit_cnt == 6'd8 + payload_len) && (payload_len != 6'd0);

  always_ff @(posedge clk) begin
    if (reset) begin
      sky_sh       <= `RBZ_DEF_SKY;
      floor_sh     <= `RBZ_DEF_FLOOR;
      vshift_sh    <= '0;
      wall_sh      <= '0;
      side_sh      <= 1'b0;
      texu_sh      <= '0;
      half_sh      <= '0;
      texadd_sh[0] <= '0;
      texadd_sh[1] <= '0;
      texadd_sh[2] <= '0;
      texadd_sh[3] <= '0;
    end else if (xfer_done) begin
      case (cmd)
        `RBZ_CMD_SKY:     sky_sh    <= payload[5:0];
        `RBZ_CMD_FLOOR:   floor_sh  <= payload[5:0];
        `RBZ_CMD_VSHIFT:  vshift_sh <= payload[5:0];
        `RBZ_CMD_SLICE: begin
          wall_sh <= payload[17:16];        // Wall id
          side_sh <= payload[15];
          texu_sh <= payload[14:9];
          half_sh <= payload[8:0];          // Half-height in pixels
        end
        `RBZ_CMD_TEXADD0: texadd_sh[0] <= payload;
        `RBZ_CMD_TEXADD1: texadd_sh[1] <= payload;
        `RBZ_CMD_TEXADD2: texadd_sh[2] <= payload;
        `RBZ_CMD_TEXADD3: texadd_sh[3] <= payload;
        default: ;
      endcase
    end
  end

  // Live copies change only between frames
  always_ff @(posedge clk) begin
    if (reset) begin
      o_sky       <= `RBZ_DEF_SKY;
      o_floor     <= `RBZ_DEF_FLOOR;
      o_vshift    <= '0;
      o_wall      <= '0;
      side_r      <= 1'b0;
      texu_r      <= '0;
      o_half_size <= '0;
      texadd_r[0] <= '0;
      texadd_r[1] <= '0;
      texadd_r[2] <= '0;
      texadd_r[3] <= '0;
    end else if (i_frame_end) begin
      o_sky       <= sky_sh;
      o_floor     <= floor_sh;
      o_vshift    <= vshift_sh;
      o_wall      <= wall_sh;
      side_r      <= side_sh;
      texu_r      <= texu_sh;
      o_half_size <= half_sh;
      texadd_r    <= texadd_sh;
    end
  end

  assign wall_idx = o_wall - 2'd1;         // Wall ids 1..3 map to textures 0..2

  always_comb begin
    o_slice_addr.f.unused   = '0;
    o_slice_addr.f.wall_idx = wall_idx;
    o_slice_addr.f.side     = side_r;
    o_slice_addr.f.texu     = texu_r;
    o_slice_addr.f.texel    = '0;          // Slice base
  end

  assign o_tex_addend = texadd_r[wall_idx];

endmodule

/* verilog/vga_sync.sv */
`timescale 1ns/1ps
`include "rbz_consts.svh"

module vga_sync (
  input  logic       clk,
  input  logic       reset,
  output logic [9:0] o_hpos,      // 0..799
  output logic [9:0] o_vpos,      // 0..524
  output logic       o_hsync,     // Active high, top inverts
  output logic       o_vsync,
  output logic       o_hblank,
  output logic       o_vblank,
  output logic       o_visible,
  output logic       o_hmax,      // Last clock of each line
  output logic       o_frame_end  // Last clock of the last visible line
);

  logic vmax;  // Last line of the frame

  assign o_hmax = (o_hpos == 10'(`RBZ_H_TOTAL - 1));
  assign vmax   = (o_vpos == 10'(`RBZ_V_TOTAL - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      o_hpos <= '0;
      o_vpos <= '0;
    end else if (o_hmax) begin
      o_hpos <= '0;                              // Wrap line
      o_vpos <= vmax ? '0 : o_vpos + 10'd1;      // Next line or new frame
    end else begin
      o_hpos <= o_hpos + 10'd1;
    end
  end

  // Sync windows straight from the counters
  assign o_hsync = (o_hpos >= 10'(`RBZ_H_SYNC_START)) && (o_hpos < 10'(`RBZ_H_SYNC_END));
  assign o_vsync = (o_vpos >= 10'(`RBZ_V_SYNC_START)) && (o_vpos < 10'(`RBZ_V_SYNC_END));

  assign o_hblank  = (o_hpos >= 10'(`RBZ_H_VIEW));
  assign o_vblank  = (o_vpos >= 10'(`RBZ_V_VIEW));
  assign o_visible = !o_hblank && !o_vblank;

  // Registers commit here, so new values take effect for the whole next frame
  assign o_frame_end = o_hmax && (o_vpos == 10'(`RBZ_V_VIEW - 1));

endmodule

/* verilog/rbz_pkg.sv */
package rbz_pkg;

  // Flash address of one wall slice, MSB first as declared
  typedef struct packed {
    logic [8:0] unused;     // Spare address range, always 0 in the base
    logic [1:0] wall_idx;   // Wall id minus one
    logic       side;       // 0 or 1
    logic [5:0] texu;       // Slice column within the texture
    logic [5:0] texel;      // Texel 0..63 within the slice, 0 in the base
  } rbz_slice_fields_t;

  // Built field by field in reg_spi, added to and shifted out raw in tex_qspi
  typedef union packed {
    logic [23:0]       raw;
    rbz_slice_fields_t f;
  } rbz_slice_addr_u;

endpackage

/* verilog/rbz_consts.svh */
`ifndef RBZ_CONSTS_SVH
`define RBZ_CONSTS_SVH

// 640x480 VGA line timing, in pixel clocks
`define RBZ_H_VIEW            640
`define RBZ_H_SYNC_START      656
`define RBZ_H_SYNC_END        752
`define RBZ_H_TOTAL           800
`define RBZ_HALF_VIEW         320

// Frame timing, in lines
`define RBZ_V_VIEW            480
`define RBZ_V_SYNC_START      490
`define RBZ_V_SYNC_END        492
`define RBZ_V_TOTAL           525

// Texture flash stream, counted in tex sclk cycles from stream start
`define RBZ_TEXEL_COUNT       64
`define RBZ_TSPI_CMD          8'h6B
`define RBZ_TSPI_CMD_LEN      8
`define RBZ_TSPI_ADDR_END     32
`define RBZ_TSPI_PREAMBLE_LEN 40
`define RBZ_TSPI_STREAM_LEN   168
`define RBZ_TSPI_READ_START   600

// Register SPI command bytes (code 4 is not assigned)
`define RBZ_CMD_SKY           8'd0
`define RBZ_CMD_FLOOR         8'd1
`define RBZ_CMD_VSHIFT        8'd2
`define RBZ_CMD_SLICE         8'd3
`define RBZ_CMD_TEXADD0       8'd5
`define RBZ_CMD_TEXADD1       8'd6
`define RBZ_CMD_TEXADD2       8'd7
`define RBZ_CMD_TEXADD3       8'd8

// Background colours out of reset, BBGGRR
`define RBZ_DEF_SKY           6'b010101
`define RBZ_DEF_FLOOR         6'b101010

`endif
